// File: bench/sort_patterns.hex
// word 0 batch count, then per batch order, length, input keys,
// expected keys in output order
0004
// full batch decreasing
0000 0010
3a7f 0012 c001 0012 ffff 4500 0000 9e3b
7777 1000 d00d 0abc 8001 2222 5e5e beef
ffff d00d c001 beef 9e3b 8001 7777 5e5e
4500 3a7f 2222 1000 0abc 0012 0012 0000
// short batch increasing, repeats and zero
0001 0005
0003 0000 0003 ffff 0010
0000 0003 0003 0010 ffff
// increasing again under credit stalls
0001 0007
1234 0001 8000 1234 7fff 0000 00ff
0000 0001 00ff 1234 1234 7fff 8000
// small decreasing batch after the stack was cleared
0000 0003
0002 0005 0001
0005 0002 0001

// File: sources.f
+incdir+rtl
rtl/sort_pkg.sv
rtl/sort_cell.sv
rtl/sort_stack.sv
rtl/sort_cfg_regs.sv
rtl/sort_flow_ctrl.sv
rtl/sort_unit_top.sv
bench/sort_unit_assert.sv
bench/sort_unit_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := sort_unit_tb
FILELIST   := sources.f
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/sort_unit_tb.sv
`timescale 1ns/1ps
`include "sort_macros.svh"

module sort_unit_tb
  import sort_pkg::*;
;

  logic      clk;
  logic      rst;
  logic      in_credit;
  logic      in_valid;
  logic      in_last;
  key_t      in_data;
  logic      out_credit;
  logic      out_valid;
  logic      out_last;
  key_t      out_data;
  logic      cfg_we;
  reg_addr_t cfg_addr;
  reg_data_t cfg_wdata;
  reg_data_t cfg_rdata;

  // pattern words, see bench/sort_patterns.hex for the layout
  logic [15:0] pat [0:255];
  int          total_keys;
  logic        loaded;

  // monitor state, updated on the rising edge
  int   batch_credits;
  int   cred_sent;
  int   pops;
  key_t got_key [$];
  logic got_last [$];
  int   last_seen;

  // one LFSR per random process
  logic [31:0] gap_lfsr;
  logic [31:0] cred_lfsr;

  sort_unit_top sort_unit_top_inst (.*);

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  task automatic take_bits(inout logic [31:0] s, input int n, output int v);
    v = 0;
    repeat (n)
    begin
      s = lfsr_next(s);
      v = (v << 1) | int'(s[0]);
    end
  endtask

  task automatic report_error(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_key(input string name, input key_t got, input key_t exp);
    if (got !== exp)
      report_error($sformatf("Error %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_error($sformatf("Error %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_stat(input string name, input reg_data_t got,
                            input reg_data_t exp);
    if (got !== exp)
      report_error($sformatf("Error %s got %h expected %h", name, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // output monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (rst)
    begin
      batch_credits <= 0;
      cred_sent     <= 0;
      pops          <= 0;
    end
    else
    begin
      // a new grant round starts after out_last
      if (out_valid && out_last)
        batch_credits <= 0;
      else if (in_credit)
        batch_credits <= batch_credits + 1;
      if (out_credit)
        cred_sent <= cred_sent + 1;
      if (out_valid)
      begin
        if (cred_sent == pops)
          report_error("out_valid seen while no output credit was outstanding");
        pops <= pops + 1;
        got_key.push_back(out_data);
        got_last.push_back(out_last);
        if (out_last)
          last_seen = last_seen + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // output credits, random with long stalls
  ////////////////////////////////////////////////////////////

  initial
  begin
    int stall;
    int r;
    stall = 0;
    @(negedge clk);
    wait (!rst);
    forever
    begin
      @(negedge clk);
      if (stall > 0)
      begin
        stall = stall - 1;
        out_credit = 1'b0;
      end
      else
      begin
        take_bits(cred_lfsr, 5, r);
        if (r == 0)
        begin
          take_bits(cred_lfsr, 4, r);
          stall = 16 + r;
        end
        take_bits(cred_lfsr, 1, r);
        // keep the DUT credit counter in range
        out_credit = (cred_sent - pops < `SORT_DEPTH) && (r == 1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    wait (loaded);
    repeat (total_keys * 64 + 2000) @(posedge clk);
    $display("timeout, the batches did not finish in time");
    $display("Regression failed");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  task automatic wait_credits();
    int n;
    n = 0;
    while (batch_credits < `SORT_DEPTH)
    begin
      @(negedge clk);
      n = n + 1;
      if (n > 200)
        report_error("a full set of input credits did not arrive");
    end
    // no extra credits may follow
    repeat (4) @(negedge clk);
    if (batch_credits != `SORT_DEPTH)
      report_error($sformatf("Error in_credit count got %h expected %h",
                             batch_credits, `SORT_DEPTH));
  endtask

  task automatic write_ctrl(input logic ord);
    cfg_we    = 1'b1;
    cfg_addr  = `SORT_REG_CTRL;
    cfg_wdata = reg_data_t'(ord);
    @(negedge clk);
    cfg_we    = 1'b0;
    // the order bit reads back from CTRL
    check_stat("cfg_rdata", cfg_rdata, reg_data_t'(ord));
    cfg_addr  = `SORT_REG_STAT;
    @(negedge clk);
  endtask

  task automatic send_batch(input int base, input int len);
    int gap;
    for (int i = 0; i < len; i++)
    begin
      take_bits(gap_lfsr, 2, gap);
      repeat (gap) @(negedge clk);
      // only against a credit already received
      while (batch_credits <= i)
        @(negedge clk);
      in_valid = 1'b1;
      in_data  = key_t'(pat[base + i]);
      in_last  = (i == len - 1);
      @(negedge clk);
      in_valid = 1'b0;
      in_last  = 1'b0;
    end
  endtask

  task automatic collect_batch(input int base, input int len, input logic ord);
    int n;
    n = 0;
    while (last_seen == 0)
    begin
      @(negedge clk);
      n = n + 1;
      if (n > len * 64 + 200)
        report_error("out_last never arrived for the batch");
    end
    repeat (4) @(negedge clk);
    if (got_key.size() != len)
      report_error($sformatf("Error key count got %h expected %h",
                             got_key.size(), len));
    for (int i = 0; i < len; i++)
    begin
      // direction follows the order bit
      if (i > 0 && !ord && got_key[i] > got_key[i-1])
        report_error("keys rose in a decreasing batch");
      if (i > 0 && ord && got_key[i] < got_key[i-1])
        report_error("keys fell in an increasing batch");
      check_key("out_data", got_key[i], key_t'(pat[base + i]));
      check_last("out_last", got_last[i], i == len - 1);
    end
    got_key.delete();
    got_last.delete();
    last_seen = 0;
  endtask

  initial
  begin
    int nbatch;
    int ptr;
    int len;
    logic ord;
    clk        = 1'b0;
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_last    = 1'b0;
    in_data    = '0;
    out_credit = 1'b0;
    cfg_we     = 1'b0;
    cfg_addr   = `SORT_REG_STAT;
    cfg_wdata  = '0;
    gap_lfsr   = 32'h2518;
    cred_lfsr  = 32'h2518;
    last_seen  = 0;
    loaded     = 1'b0;

    $readmemh("bench/sort_patterns.hex", pat);
    nbatch     = int'(pat[0]);
    total_keys = 0;
    ptr        = 1;
    for (int b = 0; b < nbatch; b++)
    begin
      total_keys = total_keys + int'(pat[ptr + 1]);
      ptr = ptr + 2 + 2 * int'(pat[ptr + 1]);
    end
    loaded = 1'b1;

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_stat("cfg_rdata", cfg_rdata, '0);

    ptr = 1;
    for (int b = 0; b < nbatch; b++)
    begin
      ord = pat[ptr][0];
      len = int'(pat[ptr + 1]);
      wait_credits();
      write_ctrl(ord);
      send_batch(ptr + 2, len);
      collect_batch(ptr + 2 + len, len, ord);
      check_stat("cfg_rdata", cfg_rdata, reg_data_t'(b + 1));
      ptr = ptr + 2 + 2 * len;
    end

    $display("Regression passed");
    $finish;
  end

endmodule

// File: bench/sort_unit_assert.sv
`timescale 1ns/1ps

module sort_unit_assert
(
  input logic clk,
  input logic rst,
  input logic in_credit,
  input logic in_valid,
  input logic out_credit,
  input logic out_valid,
  input logic out_last
);

  ////////////////////////////////////////////////////////////
  // credit bookkeeping
  ////////////////////////////////////////////////////////////

  // input credits received minus keys sent, lapsed credits stay counted
  int in_avail;
  // output credits sent minus keys popped
  int out_held;
  // keys sent in minus keys popped, the stack fill level
  int keys_held;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      in_avail  <= 0;
      out_held  <= 0;
      keys_held <= 0;
    end
    else
    begin
      in_avail  <= in_avail + int'(in_credit) - int'(in_valid);
      out_held  <= out_held + int'(out_credit) - int'(out_valid);
      keys_held <= keys_held + int'(in_valid) - int'(out_valid);
    end
  end

  // a key needs a credit received in an earlier cycle
  a_in_credit_held: assert property (@(posedge clk) disable iff (rst)
    in_valid |-> in_avail > 0)
    else $error("in_valid without a held input credit");

  // a pop needs a credit from an earlier cycle
  a_out_credit_held: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> out_held > 0)
    else $error("out_valid without a held output credit");

  // out_last only on the pop that takes the final key
  a_last_valid: assert property (@(posedge clk) disable iff (rst)
    out_last == (out_valid && keys_held == 1))
    else $error("out_last not on the final key of the batch");

  // in_credit is registered, so check from the second reset cycle on
  a_no_credit_in_rst: assert property (@(posedge clk)
    (rst && $past(rst)) |-> !in_credit)
    else $error("in_credit high during reset");

endmodule

bind sort_flow_ctrl sort_unit_assert sort_unit_assert_inst (.*);

// File: rtl/sort_unit_top.sv
`timescale 1ns/1ps
`include "sort_macros.svh"

module sort_unit_top
  import sort_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // input stream
  output logic      in_credit,
  input  logic      in_valid,
  input  logic      in_last,
  input  key_t      in_data,
  // output stream
  input  logic      out_credit,
  output logic      out_valid,
  output logic      out_last,
  output key_t      out_data,
  // register port
  input  logic      cfg_we,
  input  reg_addr_t cfg_addr,
  input  reg_data_t cfg_wdata,
  output reg_data_t cfg_rdata
);

  ////////////////////////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////////////////////////

  logic order;
  logic batch_done;
  logic stk_hold;
  logic stk_load;
  logic stk_clr;
  key_t stk_in;
  key_t stk_out;

  // order bit and batch counter
  sort_cfg_regs sort_cfg_regs_inst (
    .clk        (clk),
    .rst        (rst),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .batch_done (batch_done),
    .order      (order)
  );

  // credits, batch sequencing, key inversion
  sort_flow_ctrl sort_flow_ctrl_inst (
    .clk        (clk),
    .rst        (rst),
    .in_credit  (in_credit),
    .in_valid   (in_valid),
    .in_last    (in_last),
    .in_data    (in_data),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .out_data   (out_data),
    .order      (order),
    .batch_done (batch_done),
    .stk_hold   (stk_hold),
    .stk_load   (stk_load),
    .stk_clr    (stk_clr),
    .stk_in     (stk_in),
    .stk_out    (stk_out)
  );

  // compare-exchange chain
  sort_stack #(
    .DEPTH (`SORT_DEPTH)
  ) sort_stack_inst (
    .clk      (clk),
    .rst      (rst),
    .clr      (stk_clr),
    .hold     (stk_hold),
    .load     (stk_load),
    .data_in  (stk_in),
    .data_out (stk_out)
  );

endmodule

// File: rtl/sort_flow_ctrl.sv
`timescale 1ns/1ps
`include "sort_macros.svh"

module sort_flow_ctrl
  import sort_pkg::*;
(
  input  logic clk,
  input  logic rst,
  // input side
  output logic in_credit,
  input  logic in_valid,
  input  logic in_last,
  input  key_t in_data,
  // output side
  input  logic out_credit,
  output logic out_valid,
  output logic out_last,
  output key_t out_data,
  // register block
  input  logic order,
  output logic batch_done,
  // stack control
  output logic stk_hold,
  output logic stk_load,
  output logic stk_clr,
  output key_t stk_in,
  input  key_t stk_out
);

  localparam cnt_t DEPTH_C = cnt_t'(`SORT_DEPTH);
  localparam cnt_t LAST_C  = cnt_t'(`SORT_DEPTH - 1);

  flow_state_t state;
  flow_state_t state_next;

  // credits issued in this batch
  cnt_t grant_cnt;
  // keys in the stack
  cnt_t item_cnt;
  // output credits held
  cnt_t credit_cnt;
  // order latched at the first key of a batch
  logic order_q;
  // order used on entry, the first key sees the live bit
  logic order_in;

  logic accept;
  logic batch_end;
  logic issue;
  logic pop;
  logic last_pop;

  ////////////////////////////////////////////////////////////
  // handshake decode
  ////////////////////////////////////////////////////////////

  // keys are taken while loading only, credits left unspent
  // after in_last lapse with the batch
  assign accept    = in_valid && (state != DRAIN);
  // batch closes at in_last or at a full stack
  assign batch_end = accept && (in_last || item_cnt == LAST_C);
  // one new credit per cycle until the stack is covered
  assign issue     = (state == GRANT) && (grant_cnt != DEPTH_C) && !batch_end;
  // a pop needs both a held credit and a key left
  assign pop       = (state == DRAIN) && (credit_cnt != '0) && (item_cnt != '0);
  assign last_pop  = pop && (item_cnt == cnt_t'(1));

  ////////////////////////////////////////////////////////////
  // stack steering and order transform
  ////////////////////////////////////////////////////////////

  assign stk_load = (state != DRAIN);
  // freeze the chain unless a key moves this cycle
  assign stk_hold = !(accept || pop);
  // empty the stack together with the final pop
  assign stk_clr  = last_pop;

  assign order_in = (item_cnt == '0) ? order : order_q;
  // the stack sorts decreasing, inverted keys give increasing
  assign stk_in   = in_data ^ {`SORT_KEY_W{order_in}};
  assign out_data = stk_out ^ {`SORT_KEY_W{order_q}};

  assign out_valid  = pop;
  assign out_last   = last_pop;
  assign batch_done = last_pop;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_next = state;
    case (state)
      GRANT:
      begin
        if (batch_end)
          state_next = DRAIN;
        else if (grant_cnt == DEPTH_C)
          state_next = LOAD;
      end
      LOAD:
      begin
        if (batch_end)
          state_next = DRAIN;
      end
      DRAIN:
      begin
        if (last_pop)
          state_next = GRANT;
      end
      default:
      begin
        state_next = GRANT;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= GRANT;
      in_credit  <= 1'b0;
      grant_cnt  <= '0;
      item_cnt   <= '0;
      credit_cnt <= '0;
      order_q    <= 1'b0;
    end
    else
    begin
      state     <= state_next;
      // registered, so credits start one cycle after reset
      in_credit <= issue;
      if (last_pop)
        grant_cnt <= '0;
      else if (issue)
        grant_cnt <= grant_cnt + cnt_t'(1);
      // accept and pop never share a cycle
      if (accept)
        item_cnt <= item_cnt + cnt_t'(1);
      else if (pop)
        item_cnt <= item_cnt - cnt_t'(1);
      // credits count in any state, early ones wait for DRAIN
      if (out_credit && !pop)
        credit_cnt <= credit_cnt + cnt_t'(1);
      else if (!out_credit && pop)
        credit_cnt <= credit_cnt - cnt_t'(1);
      if (accept && item_cnt == '0)
        order_q <= order;
    end
  end

endmodule

// File: rtl/sort_cfg_regs.sv
`timescale 1ns/1ps
`include "sort_macros.svh"

module sort_cfg_regs
  import sort_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      cfg_we,
  input  reg_addr_t cfg_addr,
  input  reg_data_t cfg_wdata,
  output reg_data_t cfg_rdata,
  input  logic      batch_done,
  output logic      order
);

  // completed batches, wraps at the register width
  reg_data_t batch_cnt;

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // decreasing order after reset
      order     <= 1'b0;
      batch_cnt <= '0;
    end
    else
    begin
      // only bit 0 of CTRL is implemented
      if (cfg_we && cfg_addr == `SORT_REG_CTRL)
      begin
        order <= cfg_wdata[0];
      end
      // STAT is read only, a write to it is dropped
      if (batch_done)
      begin
        batch_cnt <= batch_cnt + reg_data_t'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  // plain mux, no read strobe
  always_comb
  begin
    cfg_rdata = '0;
    case (cfg_addr)
      `SORT_REG_CTRL:
      begin
        cfg_rdata = reg_data_t'(order);
      end
      `SORT_REG_STAT:
      begin
        cfg_rdata = batch_cnt;
      end
      default:
      begin
        cfg_rdata = '0;
      end
    endcase
  end

endmodule

// File: rtl/sort_stack.sv
`timescale 1ns/1ps
`include "sort_macros.svh"

module sort_stack
  import sort_pkg::*;
#(
  parameter int DEPTH = `SORT_DEPTH
)
(
  input  logic clk,
  input  logic rst,
  input  logic clr,
  input  logic hold,
  input  logic load,
  input  key_t data_in,
  output key_t data_out
);

  // two keys per cell
  localparam int NCELL = DEPTH / 2;

  ////////////////////////////////////////////////////////////
  // chain wiring
  ////////////////////////////////////////////////////////////

  key_t prev_w [NCELL];
  key_t next_w [NCELL];
  key_t cell_out [NCELL];

  // an odd depth would leave one key without a partner
  if ((DEPTH % 2) != 0 || DEPTH < 2)
  begin : g_depth_check
    $error("sort_stack DEPTH must be even and at least 2");
  end

  // cell 0 faces the flow controller
  assign prev_w[0] = data_in;
  // the bottom cell pulls the floor value on a pop
  assign next_w[NCELL-1] = '0;
  // largest stored key, valid while popping
  assign data_out = cell_out[0];

  for (genvar i = 0; i < NCELL; i++)
  begin : g_cell
    // pushes ripple down the chain
    if (i > 0)
    begin : g_prev
      assign prev_w[i] = cell_out[i-1];
    end
    // pops ripple up the chain
    if (i < NCELL - 1)
    begin : g_next
      assign next_w[i] = cell_out[i+1];
    end

    sort_cell sort_cell_inst (
      .clk     (clk),
      .rst     (rst),
      .clr     (clr),
      .hold    (hold),
      .load    (load),
      .in_prev (prev_w[i]),
      .in_next (next_w[i]),
      .out     (cell_out[i])
    );
  end

endmodule

// File: rtl/sort_cell.sv
`timescale 1ns/1ps
`include "sort_macros.svh"

module sort_cell
  import sort_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic clr,
  input  logic hold,
  input  logic load,
  input  key_t in_prev,
  input  key_t in_next,
  output key_t out
);

  // the pair held by this cell, higher >= lower at all times
  key_t higher;
  key_t lower;

  // the two candidates that get ordered at the next edge
  key_t cand_h;
  key_t cand_l;

  // loading keeps higher and takes a key from the cell above,
  // the old lower key moves on down the chain
  // popping keeps lower and takes the higher key of the cell below,
  // the old higher key moves up towards the output
  assign cand_h = load ? higher : lower;
  assign cand_l = load ? in_prev : in_next;

  // what leaves the cell this cycle
  assign out = load ? lower : higher;

  always_ff @(posedge clk)
  begin
    if (rst || clr)
    begin
      // zero is the floor of the order, so empty cells hold zero
      higher <= '0;
      lower  <= '0;
    end
    else if (!hold)
    begin
      // ties keep the resident key on top, the order stays stable
      higher <= (cand_h >= cand_l) ? cand_h : cand_l;
      lower  <= (cand_h >= cand_l) ? cand_l : cand_h;
    end
  end

endmodule

// File: rtl/sort_pkg.sv
`include "sort_macros.svh"

package sort_pkg;

  ////////////////////////////////////////////////////////////
  // data path types
  ////////////////////////////////////////////////////////////

  // one key as stored in the stack
  typedef logic [`SORT_KEY_W-1:0] key_t;

  // item count, grant count or held output credits
  typedef logic [`SORT_CNT_W-1:0] cnt_t;

  ////////////////////////////////////////////////////////////
  // register port types
  ////////////////////////////////////////////////////////////

  // only CTRL and STAT exist
  typedef logic [0:0] reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // flow controller states
  // GRANT  issuing input credits, keys may already arrive
  // LOAD   all credits out, waiting for the rest of the batch
  // DRAIN  popping keys against output credits
  typedef enum logic [1:0] {
    GRANT,
    LOAD,
    DRAIN
  } flow_state_t;

endpackage

// File: rtl/sort_macros.svh
`ifndef SORT_MACROS_SVH
`define SORT_MACROS_SVH

////////////////////////////////////////////////////////////
// sorter sizing
////////////////////////////////////////////////////////////

// width of one key
`define SORT_KEY_W 16
// stack capacity in keys, must stay even (two keys per cell)
`define SORT_DEPTH 16
// item and credit counters, must hold SORT_DEPTH
`define SORT_CNT_W 5

////////////////////////////////////////////////////////////
// register map
////////////////////////////////////////////////////////////

`define SORT_REG_CTRL 1'b0
`define SORT_REG_STAT 1'b1

`endif
